// File: Makefile
TOP := tb_mem_subsys

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f list.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: list.f
src/lc3b_types_pkg.sv
src/mem_bus_pkg.sv
src/indirect_seq.sv
src/mem_stage.sv
src/fetch_unit.sv
src/mem_arbiter.sv
src/unified_ram.sv
src/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// File: src/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_unit
	import lc3b_types_pkg::*;
	import mem_bus_pkg::*;
#(
	parameter lc3b_word RESET_PC = 16'h0040
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     fetch_en,
	input  logic     if_ready,
	input  logic     bus_ack,
	input  bus_rsp_t bus_rsp,
	output logic     bus_req,
	output bus_req_t bus_out,
	output if_id_t   if_out
);

	lc3b_word pc_q;      // stays on the buffered instruction until taken
	lc3b_word instr_q;
	logic     full;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q    <= RESET_PC;
			full    <= 1'b0;
			bus_req <= 1'b0;
		end else begin
			if (full && if_ready) begin
				full <= 1'b0;
				pc_q <= pc_q + 16'd2;
			end
			if (fetch_en && !full && !bus_req && !bus_ack)
				bus_req <= 1'b1;
			if (bus_req && bus_ack) begin
				bus_req <= 1'b0;
				full    <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus_req && bus_ack)
			instr_q <= bus_rsp.rdata;
	end

	always_comb begin
		bus_out.addr  = pc_q;
		bus_out.wdata = '0;
		bus_out.we    = 1'b0;   // read only
		bus_out.wmask = 2'b11;
		if_out.valid  = full;
		if_out.pc     = pc_q;
		if_out.instr  = instr_q;
	end

endmodule

`default_nettype wire

// File: src/indirect_seq.sv
`default_nettype none
`timescale 1ns/1ps

module indirect_seq (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic is_store,
	input  logic bus_ack,     // completed access with req and ack both high
	output logic ptr_phase,
	output logic load_ptr,
	output logic done
);

	typedef enum logic [1:0] {
		st_idle,
		st_ptr,     // reading the pointer word
		st_load,    // real read at the pointer
		st_store    // real write at the pointer
	} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:
					if (start)
						state <= st_ptr;
				st_ptr:
					if (bus_ack)
						state <= is_store ? st_store : st_load;
				st_load,
				st_store:
					if (bus_ack)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	assign ptr_phase = (state == st_ptr);
	assign load_ptr  = ptr_phase & bus_ack;   // pointer word is on rdata now
	assign done      = ((state == st_load) | (state == st_store)) & bus_ack;

endmodule

`default_nettype wire

// File: src/lc3b_types_pkg.sv
`default_nettype none

package lc3b_types_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [1:0]  lc3b_mem_wmask;   // bit 1 is the high byte

	// only the opcodes the memory side cares about
	typedef enum logic [3:0] {
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef struct packed {
		lc3b_opcode  opcode;
		logic        mem_read;
		logic        mem_write;
		logic        is_indirect;   // LDI / STI
		logic        is_byte;
		logic [1:0]  cc_sel;        // 0 alu, 1 mem data, 2 pc
	} ctrl_t;

	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		lc3b_word    alu_out;   // address or result
		lc3b_word    srcb_out;  // store data
		lc3b_word    pc_out;
		lc3b_word    intr;
		logic [2:0]  destreg;
	} ex_mem_t;

	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		logic [2:0]  destreg;
		lc3b_word    pc_out;
		lc3b_word    mem_data;
		lc3b_word    regfile_data;
	} mem_wb_t;

	typedef struct packed {
		logic        valid;
		lc3b_word    pc;
		lc3b_word    instr;
	} if_id_t;

endpackage

`default_nettype wire

// File: src/mem_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter
	import mem_bus_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic     [1:0] m_req,
	input  bus_req_t [1:0] m_out,
	input  logic           ram_ack,
	input  bus_rsp_t       ram_rsp,
	output logic     [1:0] m_ack,
	output bus_rsp_t       m_rsp,
	output logic           ram_req,
	output bus_req_t       ram_out
);

	logic busy;     // grant held
	logic acked;    // owner's ack has been seen
	logic owner;
	logic last;     // requester served last
	logic pick;

	// round robin where the one not served last wins a tie
	always_comb begin
		if (m_req == 2'b11)
			pick = ~last;
		else
			pick = m_req[1];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			acked <= 1'b0;
			owner <= 1'b0;
			last  <= 1'b1;   // first tie goes to the memory stage
		end else if (!busy) begin
			if (|m_req && !ram_ack) begin
				busy  <= 1'b1;
				owner <= pick;
				last  <= pick;
			end
		end else begin
			if (ram_ack)
				acked <= 1'b1;
			if (acked && !ram_ack) begin   // link idle again after all four phases
				busy  <= 1'b0;
				acked <= 1'b0;
			end
		end
	end

	assign ram_req = busy & m_req[owner];
	assign ram_out = m_out[owner];
	assign m_rsp   = ram_rsp;

	always_comb begin
		m_ack        = '0;
		m_ack[owner] = busy & ram_ack;
	end

endmodule

`default_nettype wire

// File: src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	import lc3b_types_pkg::*;

	// one request on the shared memory port with a byte address
	typedef struct packed {
		lc3b_word       addr;
		lc3b_word       wdata;
		logic           we;
		lc3b_mem_wmask  wmask;
	} bus_req_t;

	typedef struct packed {
		lc3b_word       rdata;   // valid while ack is high
	} bus_rsp_t;

endpackage

`default_nettype wire

// File: src/mem_stage.sv
`default_nettype none
`timescale 1ns/1ps

module mem_stage
	import lc3b_types_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  ex_mem_t  ex_in,
	input  logic     bus_ack,
	input  bus_rsp_t bus_rsp,
	output logic     ex_ready,
	output logic     bus_req,
	output bus_req_t bus_out,
	output mem_wb_t  mem_wb_out
);

	ex_mem_t  ex_q;        // op held while the bus works on it
	lc3b_word ptr_q;
	mem_wb_t  wb_q;
	logic     wb_valid;
	logic     busy;
	logic     accept;
	logic     in_mem_op;
	logic     acc_done;
	logic     final_ack;
	logic     ptr_phase;
	logic     load_ptr;
	logic     seq_done;
	lc3b_word trap_vec;
	lc3b_word addr;
	lc3b_word wdata;
	lc3b_word load_data;
	lc3b_word mem_data;

	// writeback word with the cc mux applied
	function automatic mem_wb_t build_wb(input ex_mem_t e, input lc3b_word md);
		mem_wb_t w;
		w.valid    = 1'b1;
		w.ctrl     = e.ctrl;
		w.destreg  = e.destreg;
		w.pc_out   = e.pc_out;
		w.mem_data = md;
		case (e.ctrl.cc_sel)
			2'd0:    w.regfile_data = e.alu_out;
			2'd1:    w.regfile_data = md;
			2'd2:    w.regfile_data = e.pc_out;
			default: w.regfile_data = '0;
		endcase
		return w;
	endfunction

	assign accept    = ex_in.valid & ex_ready;
	assign in_mem_op = ex_in.ctrl.mem_read | ex_in.ctrl.mem_write;
	assign ex_ready  = ~busy;
	assign acc_done  = bus_req & bus_ack;   // one edge per access

	indirect_seq u_seq (
		.clk       (clk),
		.reset     (reset),
		.start     (accept & in_mem_op & ex_in.ctrl.is_indirect),
		.is_store  (ex_in.ctrl.mem_write),
		.bus_ack   (acc_done),
		.ptr_phase (ptr_phase),
		.load_ptr  (load_ptr),
		.done      (seq_done)
	);

	assign trap_vec = {7'b0, ex_q.intr[7:0], 1'b0};   // trapvect8 * 2

	always_comb begin
		if (ex_q.ctrl.opcode == op_trap)
			addr = trap_vec;
		else if (ex_q.ctrl.is_indirect && !ptr_phase)
			addr = ptr_q;   // second access of LDI / STI
		else
			addr = ex_q.alu_out;
	end

	assign wdata = ex_q.ctrl.is_byte ? {2{ex_q.srcb_out[7:0]}} : ex_q.srcb_out;

	always_comb begin
		bus_out.addr  = addr;
		bus_out.wdata = wdata;
		bus_out.we    = ex_q.ctrl.mem_write & ~ptr_phase;   // pointer fetch always reads
		if (!ex_q.ctrl.is_byte)
			bus_out.wmask = 2'b11;
		else
			bus_out.wmask = addr[0] ? 2'b10 : 2'b01;
	end

	// byte loads pick the lane by address bit 0
	assign load_data = ex_q.ctrl.is_byte ?
		{8'h00, (addr[0] ? bus_rsp.rdata[15:8] : bus_rsp.rdata[7:0])} : bus_rsp.rdata;
	assign mem_data  = ex_q.ctrl.mem_write ? wdata : load_data;
	assign final_ack = ex_q.ctrl.is_indirect ? seq_done : acc_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy     <= 1'b0;
			bus_req  <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			if (accept) begin
				busy     <= in_mem_op;
				wb_valid <= ~in_mem_op;   // non-memory ops go straight through
			end
			if (busy && !bus_req && !bus_ack)
				bus_req <= 1'b1;
			if (acc_done)
				bus_req <= 1'b0;
			if (busy && final_ack) begin
				busy     <= 1'b0;
				wb_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			ex_q <= ex_in;
		if (load_ptr)
			ptr_q <= bus_rsp.rdata;
		if (accept && !in_mem_op)
			wb_q <= build_wb(ex_in, '0);
		else if (busy && final_ack)
			wb_q <= build_wb(ex_q, mem_data);
	end

	always_comb begin
		mem_wb_out       = wb_q;
		mem_wb_out.valid = wb_valid;
	end

endmodule

`default_nettype wire

// File: src/mem_subsys_top.sv
`default_nettype none
`timescale 1ns/1ps

module mem_subsys_top
	import lc3b_types_pkg::*;
	import mem_bus_pkg::*;
#(
	parameter int       ADDR_BITS   = 8,
	parameter int       RAM_LATENCY = 2,
	parameter lc3b_word RESET_PC    = 16'h0040
) (
	input  logic    clk,
	input  logic    reset,
	input  ex_mem_t ex_in,
	input  logic    fetch_en,
	input  logic    if_ready,
	output logic    ex_ready,
	output mem_wb_t mem_wb_out,
	output if_id_t  if_out
);

	logic     [1:0] m_req;   // 0 memory stage, 1 fetch
	logic     [1:0] m_ack;
	bus_req_t [1:0] m_out;
	bus_rsp_t       m_rsp;
	logic           ram_req;
	logic           ram_ack;
	bus_req_t       ram_out;
	bus_rsp_t       ram_rsp;

	mem_stage u_mem_stage (
		.clk        (clk),
		.reset      (reset),
		.ex_in      (ex_in),
		.bus_ack    (m_ack[0]),
		.bus_rsp    (m_rsp),
		.ex_ready   (ex_ready),
		.bus_req    (m_req[0]),
		.bus_out    (m_out[0]),
		.mem_wb_out (mem_wb_out)
	);

	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
		.clk      (clk),
		.reset    (reset),
		.fetch_en (fetch_en),
		.if_ready (if_ready),
		.bus_ack  (m_ack[1]),
		.bus_rsp  (m_rsp),
		.bus_req  (m_req[1]),
		.bus_out  (m_out[1]),
		.if_out   (if_out)
	);

	mem_arbiter u_arb (
		.clk     (clk),
		.reset   (reset),
		.m_req   (m_req),
		.m_out   (m_out),
		.ram_ack (ram_ack),
		.ram_rsp (ram_rsp),
		.m_ack   (m_ack),
		.m_rsp   (m_rsp),
		.ram_req (ram_req),
		.ram_out (ram_out)
	);

	unified_ram #(.ADDR_BITS(ADDR_BITS), .RAM_LATENCY(RAM_LATENCY)) u_ram (
		.clk    (clk),
		.reset  (reset),
		.req    (ram_req),
		.req_in (ram_out),
		.ack    (ram_ack),
		.rsp    (ram_rsp)
	);

endmodule

`default_nettype wire

// File: src/unified_ram.sv
`default_nettype none
`timescale 1ns/1ps

module unified_ram
	import lc3b_types_pkg::*;
	import mem_bus_pkg::*;
#(
	parameter int ADDR_BITS   = 8,
	parameter int RAM_LATENCY = 2
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     req,
	input  bus_req_t req_in,
	output logic     ack,
	output bus_rsp_t rsp
);

	localparam int CNT_BITS = $clog2(RAM_LATENCY + 1);

	lc3b_word               mem [2**ADDR_BITS];
	logic [CNT_BITS-1:0]    cnt;
	logic [ADDR_BITS-1:0]   word_addr;
	logic                   fire;

	assign word_addr = req_in.addr[ADDR_BITS:1];   // byte to word address
	assign fire      = req & ~ack & (cnt == CNT_BITS'(RAM_LATENCY - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			cnt <= '0;
		end else if (fire) begin
			ack <= 1'b1;
			cnt <= '0;
		end else if (req && !ack) begin
			cnt <= cnt + 1'b1;
		end else if (ack && !req) begin
			ack <= 1'b0;
		end
	end

	// access happens on the cycle ack rises
	always_ff @(posedge clk) begin
		if (fire) begin
			rsp.rdata <= mem[word_addr];
			if (req_in.we && req_in.wmask[0])
				mem[word_addr][7:0] <= req_in.wdata[7:0];
			if (req_in.we && req_in.wmask[1])
				mem[word_addr][15:8] <= req_in.wdata[15:8];
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_mem_subsys.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mem_subsys
	import lc3b_types_pkg::*;
();

	localparam lc3b_word RESET_PC = 16'h0040;
	localparam int       TIMEOUT  = 200;   // cycles per wait

	logic     clk;
	logic     reset;
	ex_mem_t  ex_in;
	logic     fetch_en;
	logic     if_ready;
	logic     ex_ready;
	mem_wb_t  mem_wb_out;
	if_id_t   if_out;

	logic [7:0] ref_mem [512];   // byte image of the RAM with the low byte at the even address
	int         test_errs;
	int         total_errs;
	int         n_tests;
	int         failed_tests;

	mem_subsys_top #(
		.ADDR_BITS   (8),
		.RAM_LATENCY (2),
		.RESET_PC    (RESET_PC)
	) DUT (
		.clk        (clk),
		.reset      (reset),
		.ex_in      (ex_in),
		.fetch_en   (fetch_en),
		.if_ready   (if_ready),
		.ex_ready   (ex_ready),
		.mem_wb_out (mem_wb_out),
		.if_out     (if_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// all driving happens 2 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out waiting for %s", what);
		$display("Something failed");
		$finish;
	endtask

	task automatic check_val(input string what, input lc3b_word got, input lc3b_word exp);
		assert (got === exp) else begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			test_errs++;
		end
	endtask

	task automatic expect_bit(input string what, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %-12s %s (%0d errors)", name, (test_errs == 0) ? "passed" : "FAILED",
			test_errs);
		n_tests++;
		total_errs += test_errs;
		if (test_errs != 0)
			failed_tests++;
		test_errs = 0;
	endtask

	function automatic lc3b_word ref_word(input lc3b_word a);
		return {ref_mem[{a[8:1], 1'b1}], ref_mem[{a[8:1], 1'b0}]};
	endfunction

	// control bits as decode would set them for each opcode
	function automatic ex_mem_t make_op(input lc3b_opcode opc, input lc3b_word alu,
		input lc3b_word srcb);
		ex_mem_t e;
		e = '0;
		e.ctrl.opcode      = opc;
		e.ctrl.mem_read    = opc inside {op_ldr, op_ldb, op_ldi, op_trap};
		e.ctrl.mem_write   = opc inside {op_str, op_stb, op_sti};
		e.ctrl.is_indirect = opc inside {op_ldi, op_sti};
		e.ctrl.is_byte     = opc inside {op_ldb, op_stb};
		case (opc)
			op_ldr, op_ldb, op_ldi: e.ctrl.cc_sel = 2'd1;   // loaded data
			op_trap:                e.ctrl.cc_sel = 2'd2;
			default:                e.ctrl.cc_sel = 2'd0;
		endcase
		e.alu_out  = alu;
		e.srcb_out = srcb;
		e.pc_out   = 16'($urandom);
		e.intr     = {opc, 12'h000};
		e.destreg  = 3'($urandom);
		return e;
	endfunction

	// lat counts edges from the accept edge and is 1 for valid right after it
	task automatic run_op(input ex_mem_t op, output mem_wb_t res, output int lat);
		int waited;
		waited = 0;
		while (!ex_ready) begin
			step_cycle();
			waited++;
			if (waited > TIMEOUT)
				timeout_fail("ex_ready");
		end
		ex_in       = op;
		ex_in.valid = 1'b1;
		step_cycle();
		ex_in.valid = 1'b0;   // rest of the latch stays put
		lat = 1;
		while (!mem_wb_out.valid) begin
			expect_bit("ex_ready while busy", ex_ready, 1'b0);
			step_cycle();
			lat++;
			if (lat > TIMEOUT)
				timeout_fail("mem_wb_out.valid");
		end
		res = mem_wb_out;
		check_val("wb ctrl", {6'b0, res.ctrl}, {6'b0, op.ctrl});
		check_val("wb pc_out", res.pc_out, op.pc_out);
		check_val("wb destreg", {13'b0, res.destreg}, {13'b0, op.destreg});
	endtask

	task automatic store_word(input lc3b_word a, input lc3b_word d);
		mem_wb_t res;
		int      lat;
		run_op(make_op(op_str, a, d), res, lat);
		check_val("STR mem_data", res.mem_data, d);
		ref_mem[{a[8:1], 1'b0}] = d[7:0];
		ref_mem[{a[8:1], 1'b1}] = d[15:8];
	endtask

	task automatic load_word(input lc3b_word a);
		mem_wb_t res;
		int      lat;
		run_op(make_op(op_ldr, a, 16'h0000), res, lat);
		check_val("LDR mem_data", res.mem_data, ref_word(a));
		check_val("LDR regfile_data", res.regfile_data, ref_word(a));
	endtask

	task automatic store_byte(input lc3b_word a, input logic [7:0] b);
		mem_wb_t res;
		int      lat;
		run_op(make_op(op_stb, a, {8'($urandom), b}), res, lat);
		check_val("STB mem_data", res.mem_data, {b, b});   // byte goes out on both lanes
		ref_mem[a[8:0]] = b;
	endtask

	task automatic load_byte(input lc3b_word a);
		mem_wb_t res;
		int      lat;
		run_op(make_op(op_ldb, a, 16'h0000), res, lat);
		check_val("LDB mem_data", res.mem_data, {8'h00, ref_mem[a[8:0]]});
	endtask

	task automatic reset_and_add();
		ex_mem_t op;
		mem_wb_t res;
		int      lat;
		expect_bit("ex_ready after reset", ex_ready, 1'b1);
		expect_bit("mem_wb_out.valid after reset", mem_wb_out.valid, 1'b0);
		expect_bit("if_out.valid after reset", if_out.valid, 1'b0);
		op = make_op(op_add, 16'($urandom), 16'($urandom));
		run_op(op, res, lat);
		assert (lat == 1) else begin
			$display("Error at %0t ns: ADD result after %0d cycles, expected 1", $time, lat);
			test_errs++;
		end
		check_val("ADD regfile_data", res.regfile_data, op.alu_out);
		step_cycle();
		expect_bit("ADD valid second cycle", mem_wb_out.valid, 1'b0);
		finish_test("reset_add");
	endtask

	task automatic word_and_byte();
		int i;
		for (i = 0; i < 8; i++)
			store_word(16'h0100 + 16'(2 * i), 16'($urandom));
		for (i = 0; i < 8; i++)
			load_word(16'h0100 + 16'(2 * i));
		store_byte(16'h0103, 8'($urandom));   // high lane only
		load_word(16'h0102);
		load_byte(16'h0103);
		load_byte(16'h0102);
		store_byte(16'h0104, 8'($urandom));   // low lane only
		load_word(16'h0104);
		load_byte(16'h0104);
		load_byte(16'h0105);
		finish_test("word_byte");
	endtask

	task automatic indirect_access();
		lc3b_word ptr_addr;
		lc3b_word target;
		lc3b_word d;
		mem_wb_t  res;
		int       lat;
		ptr_addr = 16'h0180;
		target   = 16'h01a0;
		d        = 16'($urandom);
		store_word(ptr_addr, target);
		run_op(make_op(op_sti, ptr_addr, d), res, lat);
		check_val("STI mem_data", res.mem_data, d);
		ref_mem[{target[8:1], 1'b0}] = d[7:0];
		ref_mem[{target[8:1], 1'b1}] = d[15:8];
		load_word(target);
		run_op(make_op(op_ldi, ptr_addr, 16'h0000), res, lat);
		check_val("LDI mem_data", res.mem_data, ref_word(target));
		check_val("LDI regfile_data", res.regfile_data, ref_word(target));
		load_word(ptr_addr);   // pointer itself is unchanged
		finish_test("indirect");
	endtask

	task automatic trap_vector();
		logic [7:0] vect;
		lc3b_word   handler;
		ex_mem_t    op;
		mem_wb_t    res;
		int         lat;
		vect    = 8'hc8;
		handler = 16'($urandom);
		store_word({8'h00, vect} * 16'd2, handler);
		op = make_op(op_trap, 16'($urandom), 16'h0000);
		op.intr = {4'hf, 4'h0, vect};
		run_op(op, res, lat);
		check_val("TRAP mem_data", res.mem_data, handler);
		check_val("TRAP regfile_data", res.regfile_data, op.pc_out);
		finish_test("trap");
	endtask

	task automatic take_instrs(input int n);
		int       got;
		int       waited;
		lc3b_word exp_pc;
		got    = 0;
		exp_pc = RESET_PC;
		while (got < n) begin
			waited = 0;
			while (!if_out.valid) begin
				step_cycle();
				waited++;
				if (waited > TIMEOUT)
					timeout_fail("if_out.valid");
			end
			repeat ($urandom_range(0, 2))
				step_cycle();   // buffer must hold while not taken
			expect_bit("if_out.valid while held", if_out.valid, 1'b1);
			check_val("fetch pc", if_out.pc, exp_pc);
			check_val("fetch instr", if_out.instr, ref_word(exp_pc));
			if_ready = 1'b1;
			step_cycle();
			if_ready = 1'b0;
			exp_pc = exp_pc + 16'd2;
			got++;
		end
	endtask

	task automatic random_loads(input int n);
		int i;
		for (i = 0; i < n; i++)
			load_word(RESET_PC + 16'(2 * $urandom_range(0, 15)));
	endtask

	task automatic shared_port_traffic();
		int i;
		for (i = 0; i < 16; i++)
			store_word(RESET_PC + 16'(2 * i), 16'($urandom));
		fetch_en = 1'b1;
		fork
			take_instrs(10);
			random_loads(10);
		join
		fetch_en = 1'b0;
		finish_test("arbitration");
	endtask

	initial begin
		void'($urandom(40061));
		reset        = 1'b1;
		ex_in        = '0;
		fetch_en     = 1'b0;
		if_ready     = 1'b0;
		test_errs    = 0;
		total_errs   = 0;
		n_tests      = 0;
		failed_tests = 0;
		repeat (4)
			@(posedge clk);
		#2;
		reset = 1'b0;
		reset_and_add();
		word_and_byte();
		indirect_access();
		trap_vector();
		shared_port_traffic();
		$display("%0d tests, %0d failed, %0d errors", n_tests, failed_tests, total_errs);
		if (total_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
